//--- design/adc_link_pkg.sv
`default_nettype none

package adc_link_pkg;

  ////////////////////////////////////////
  // ADC link geometry
  ////////////////////////////////////////

  localparam int unsigned NUM_CHIPS      = 8;  // Serial LVDS ADC chips on the board.
  localparam int unsigned LANES_PER_CHIP = 8;  // Data lanes per chip.
  localparam int unsigned SAMPLE_BITS    = 8;  // Bits in one sample word.
  localparam int unsigned PAIRS_PER_WORD = 4;  // Bit clock cycles per word.

  // The frame clock rides on top of the data lanes.
  localparam int unsigned CHIP_INPUTS    = LANES_PER_CHIP + 1;
  localparam int unsigned CHIP_DATA_BITS = LANES_PER_CHIP * SAMPLE_BITS;

  localparam int unsigned PAIR_CNT_BITS  = $clog2(PAIRS_PER_WORD);
  localparam logic [PAIR_CNT_BITS-1:0] LAST_PAIR = PAIR_CNT_BITS'(PAIRS_PER_WORD - 1);

  // Four ones then four zeros, MSB first.
  localparam logic [SAMPLE_BITS-1:0] FRAME_WORD = 8'hF0;

endpackage

`default_nettype wire

//--- design/adc_align_pkg.sv
`default_nettype none

package adc_align_pkg;

  ////////////////////////////////////////
  // Word alignment controller
  ////////////////////////////////////////

  localparam int unsigned CNT_BITS = 3;  // Wide enough for both word counts.

  localparam logic [CNT_BITS-1:0] LOCK_WORDS       = 3'd4;  // Good frames before lock.
  localparam logic [CNT_BITS-1:0] SLIP_GUARD_WORDS = 3'd2;  // Words skipped after a slip.

  typedef enum logic [1:0] {
    SEARCH = 2'd0,
    GUARD  = 2'd1,
    LOCKED = 2'd2
  } align_state_t;

endpackage

`default_nettype wire

//--- design/adc_ddr_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_ddr_capture (
  input  wire logic                                 adc_clk,
  input  wire logic                                 rst_n,
  input  wire logic [adc_link_pkg::CHIP_INPUTS-1:0] in_bits,
  output logic      [adc_link_pkg::CHIP_INPUTS-1:0] rise,
  output logic      [adc_link_pkg::CHIP_INPUTS-1:0] fall
);

  logic [adc_link_pkg::CHIP_INPUTS-1:0] rise_hold;
  logic [adc_link_pkg::CHIP_INPUTS-1:0] fall_hold;

  ////////////////////////////////////////
  // Edge samplers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    rise_hold <= in_bits;  // First bit of the cycle.
  end

  always_ff @(negedge adc_clk) begin
    fall_hold <= in_bits;  // Second bit, half a cycle later.
  end

  ////////////////////////////////////////
  // Same edge pipelined output
  ////////////////////////////////////////

  // Both bits of one cycle leave together on the next rising edge.
  always_ff @(posedge adc_clk) begin
    rise <= rise_hold;
    fall <= fall_hold;
  end

endmodule

`default_nettype wire

//--- design/adc_frame_deser.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frame_deser (
  input  wire logic                                    adc_clk,
  input  wire logic                                    rst_n,
  input  wire logic [adc_link_pkg::CHIP_INPUTS-1:0]    rise,
  input  wire logic [adc_link_pkg::CHIP_INPUTS-1:0]    fall,
  input  wire logic                                    slip,
  output logic                                         word_valid,
  output logic      [adc_link_pkg::CHIP_DATA_BITS-1:0] lane_words,
  output logic      [adc_link_pkg::SAMPLE_BITS-1:0]    frame_word
);

  logic [adc_link_pkg::SAMPLE_BITS-1:0]   shreg      [adc_link_pkg::CHIP_INPUTS];
  logic [adc_link_pkg::SAMPLE_BITS-1:0]   shift_next [adc_link_pkg::CHIP_INPUTS];
  logic [adc_link_pkg::PAIR_CNT_BITS-1:0] pair_cnt;
  logic                                   wrap;

  ////////////////////////////////////////
  // Two bits per cycle, rise first
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < adc_link_pkg::CHIP_INPUTS; i++) begin
      shift_next[i] = {shreg[i][adc_link_pkg::SAMPLE_BITS-3:0], rise[i], fall[i]};
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < adc_link_pkg::CHIP_INPUTS; i++) begin
      shreg[i] <= shift_next[i];
    end
  end

  ////////////////////////////////////////
  // Word boundary
  ////////////////////////////////////////

  // A held count stretches the current word by one pair.
  assign wrap = (pair_cnt == adc_link_pkg::LAST_PAIR) && !slip;

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_cnt   <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= wrap;
      if (!slip) begin
        pair_cnt <= pair_cnt + 1'b1;  // Power of two, so it wraps by itself.
      end
    end
  end

  // Words hold between strobes. Lane 0 sits in the low byte.
  always_ff @(posedge adc_clk) begin
    if (wrap) begin
      for (int i = 0; i < adc_link_pkg::LANES_PER_CHIP; i++) begin
        lane_words[i*adc_link_pkg::SAMPLE_BITS +: adc_link_pkg::SAMPLE_BITS] <= shift_next[i];
      end
      frame_word <= shift_next[adc_link_pkg::LANES_PER_CHIP];
    end
  end

endmodule

`default_nettype wire

//--- design/adc_frame_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frame_aligner (
  input  wire logic                                 adc_clk,
  input  wire logic                                 rst_n,
  input  wire logic                                 word_valid,
  input  wire logic [adc_link_pkg::SAMPLE_BITS-1:0] frame_word,
  output logic                                      slip,
  output logic                                      locked
);

  adc_align_pkg::align_state_t            state;
  logic [adc_align_pkg::CNT_BITS-1:0]     word_cnt;  // Matches in SEARCH, skips in GUARD.
  logic                                   match;

  assign match  = (frame_word == adc_link_pkg::FRAME_WORD);
  assign locked = (state == adc_align_pkg::LOCKED);

  ////////////////////////////////////////
  // Alignment FSM
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= adc_align_pkg::SEARCH;
      word_cnt <= '0;
      slip     <= 1'b0;
    end else begin
      slip <= 1'b0;
      if (word_valid) begin
        case (state)
          adc_align_pkg::SEARCH: begin
            if (!match) begin
              slip     <= 1'b1;  // Move the boundary by one pair and retry.
              state    <= adc_align_pkg::GUARD;
              word_cnt <= '0;
            end else if (word_cnt == adc_align_pkg::LOCK_WORDS - 1'b1) begin
              state    <= adc_align_pkg::LOCKED;
              word_cnt <= '0;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
          adc_align_pkg::GUARD: begin
            // Words straddling the slip are not judged.
            if (word_cnt == adc_align_pkg::SLIP_GUARD_WORDS - 1'b1) begin
              state    <= adc_align_pkg::SEARCH;
              word_cnt <= '0;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
          adc_align_pkg::LOCKED: begin
            if (!match) begin
              slip     <= 1'b1;  // One bad frame drops lock.
              state    <= adc_align_pkg::GUARD;
              word_cnt <= '0;
            end
          end
          default: begin
            state    <= adc_align_pkg::SEARCH;
            word_cnt <= '0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top (
  input  wire logic                                  adc_clk,
  input  wire logic                                  rst_n,
  input  wire logic [adc_link_pkg::NUM_CHIPS*adc_link_pkg::LANES_PER_CHIP-1:0] in_lanes,
  input  wire logic [adc_link_pkg::NUM_CHIPS-1:0]    in_frame,
  output logic [adc_link_pkg::NUM_CHIPS*adc_link_pkg::CHIP_DATA_BITS-1:0] sample_data,
  output logic [adc_link_pkg::NUM_CHIPS-1:0]         sample_valid,
  output logic [adc_link_pkg::NUM_CHIPS-1:0]         locked
);

  ////////////////////////////////////////
  // One chain per ADC chip
  ////////////////////////////////////////

  for (genvar c = 0; c < adc_link_pkg::NUM_CHIPS; c++) begin : g_chip
    logic [adc_link_pkg::CHIP_INPUTS-1:0] rise;
    logic [adc_link_pkg::CHIP_INPUTS-1:0] fall;
    logic [adc_link_pkg::SAMPLE_BITS-1:0] frame_word;
    logic                                 slip;

    // Frame clock goes on top of the eight lanes.
    adc_ddr_capture capture_i (
      .adc_clk (adc_clk),
      .rst_n   (rst_n),
      .in_bits ({in_frame[c],
                 in_lanes[c*adc_link_pkg::LANES_PER_CHIP +: adc_link_pkg::LANES_PER_CHIP]}),
      .rise    (rise),
      .fall    (fall)
    );

    // Chip 0 occupies the low end of sample_data.
    adc_frame_deser deser_i (
      .adc_clk    (adc_clk),
      .rst_n      (rst_n),
      .rise       (rise),
      .fall       (fall),
      .slip       (slip),
      .word_valid (sample_valid[c]),
      .lane_words (sample_data[c*adc_link_pkg::CHIP_DATA_BITS +: adc_link_pkg::CHIP_DATA_BITS]),
      .frame_word (frame_word)
    );

    adc_frame_aligner aligner_i (
      .adc_clk    (adc_clk),
      .rst_n      (rst_n),
      .word_valid (sample_valid[c]),
      .frame_word (frame_word),
      .slip       (slip),
      .locked     (locked[c])
    );
  end

endmodule

`default_nettype wire

//--- sim/adc_capture_properties.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_properties (
  input wire logic                                 adc_clk,
  input wire logic                                 rst_n,
  input wire logic                                 word_valid,
  input wire logic [adc_link_pkg::SAMPLE_BITS-1:0] frame_word,
  input wire logic                                 slip,
  input wire logic                                 locked
);

  ////////////////////////////////////////
  // Reset behavior
  ////////////////////////////////////////

  reset_quiet: assert property (@(posedge adc_clk) !rst_n |-> !word_valid && !slip && !locked)
    else $error("Strobe or lock active while in reset.");

  reset_exit: assert property (@(posedge adc_clk) $rose(rst_n) |-> !word_valid && !slip && !locked)
    else $error("Strobe or lock active right after reset.");

  ////////////////////////////////////////
  // Word timing and lock
  ////////////////////////////////////////

  // Without a slip the next word follows exactly four cycles later.
  word_period: assert property (@(posedge adc_clk) disable iff (!rst_n)
    word_valid ##1 !slip |-> ##1 !word_valid ##1 !word_valid ##1 word_valid)
    else $error("Word strobe period is not four cycles.");

  lock_on_frame: assert property (@(posedge adc_clk) disable iff (!rst_n)
    $rose(locked) |-> frame_word == adc_link_pkg::FRAME_WORD)
    else $error("Lock declared on a wrong frame word.");

  lock_drop: assert property (@(posedge adc_clk) disable iff (!rst_n)
    locked && word_valid && frame_word != adc_link_pkg::FRAME_WORD |=> !locked && slip)
    else $error("Bad frame word while locked did not drop lock with a slip.");

  fall_with_slip: assert property (@(posedge adc_clk) disable iff (!rst_n)
    $fell(locked) |-> slip)
    else $error("Lock fell without a slip.");

endmodule

bind adc_frame_aligner adc_capture_properties aligner_props_i (
  .adc_clk    (adc_clk),
  .rst_n      (rst_n),
  .word_valid (word_valid),
  .frame_word (frame_word),
  .slip       (slip),
  .locked     (locked)
);

// The deser has no lock view, so only its timing rules apply there.
bind adc_frame_deser adc_capture_properties deser_props_i (
  .adc_clk    (adc_clk),
  .rst_n      (rst_n),
  .word_valid (word_valid),
  .frame_word (frame_word),
  .slip       (slip),
  .locked     (1'b0)
);

`default_nettype wire

//--- sim/adc_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_tb;

  localparam int NC = adc_link_pkg::NUM_CHIPS;
  localparam int NL = adc_link_pkg::LANES_PER_CHIP;
  localparam int CB = adc_link_pkg::CHIP_DATA_BITS;

  logic              adc_clk = 1'b0;
  logic              rst_n = 1'b0;
  logic [NC*NL-1:0]  in_lanes = '0;
  logic [NC-1:0]     in_frame = '0;
  logic [NC*CB-1:0]  sample_data;
  logic [NC-1:0]     sample_valid;
  logic [NC-1:0]     locked;

  logic [31:0] lfsr = 32'h1dcd;
  logic [7:0]  byte_tab [NC][256][NL];  // Lane 0 entries stay unused.
  logic [7:0]  word_cnt [NC];
  int          pair_idx [NC];
  bit          insert_req [NC];
  bit          have_prev [NC];
  logic [7:0]  prev_cnt [NC];
  bit          stim_ready = 1'b0;
  bit          lock_watch = 1'b0;
  bit          realigning = 1'b0;
  bit          relocked = 1'b0;
  int          realign_chip = 0;
  int          checks = 0;
  int          errors = 0;
  int          post_checks = 0;

  adc_capture_top dut_i (
    .adc_clk      (adc_clk),
    .rst_n        (rst_n),
    .in_lanes     (in_lanes),
    .in_frame     (in_frame),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .locked       (locked)
  );

  always #20 adc_clk = ~adc_clk;

  // Fibonacci LFSR, taps 32, 22, 2 and 1.
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Serializer model
  ////////////////////////////////////////

  task automatic drive_half(input int second);
    logic [7:0] b;
    int pos;
    for (int c = 0; c < NC; c++) begin
      pos = 7 - 2 * pair_idx[c] - second;  // MSB goes out first.
      for (int l = 0; l < NL; l++) begin
        b = (l == 0) ? word_cnt[c] : byte_tab[c][word_cnt[c]][l];
        in_lanes[c*NL+l] = stim_ready ? b[pos] : 1'b0;
      end
      in_frame[c] = stim_ready ? adc_link_pkg::FRAME_WORD[pos] : 1'b0;
    end
  endtask

  // First bit of a pair is sampled on the rising edge, second on the falling one.
  always @(negedge adc_clk) begin
    #10;
    drive_half(0);
  end

  always @(posedge adc_clk) begin
    #10;
    drive_half(1);
    for (int c = 0; c < NC; c++) begin
      if (stim_ready && insert_req[c]) begin
        insert_req[c] = 1'b0;  // The same pair goes out twice.
      end else if (stim_ready) begin
        pair_idx[c] = (pair_idx[c] + 1) % adc_link_pkg::PAIRS_PER_WORD;
        if (pair_idx[c] == 0) word_cnt[c] = word_cnt[c] + 8'd1;
      end
    end
  end

  ////////////////////////////////////////
  // Data scoreboard
  ////////////////////////////////////////

  always @(negedge adc_clk) begin
    logic [7:0] cnt;
    logic [7:0] got;
    if (rst_n) begin
      for (int c = 0; c < NC; c++) begin
        if (sample_valid[c] && locked[c] && !(realigning && c == realign_chip)) begin
          cnt = sample_data[c*CB +: 8];
          for (int l = 1; l < NL; l++) begin
            got = sample_data[c*CB+l*8 +: 8];
            checks++;
            assert (got == byte_tab[c][cnt][l]) else begin
              errors++;
              $display("FAILED lane_data chip %0d lane %0d: expected %h, actual %h",
                       c, l, byte_tab[c][cnt][l], got);
            end
          end
          if (have_prev[c]) begin
            checks++;
            assert (cnt == prev_cnt[c] + 8'd1) else begin
              errors++;
              $display("FAILED word_count chip %0d: expected %h, actual %h",
                       c, prev_cnt[c] + 8'd1, cnt);
            end
          end
          prev_cnt[c] = cnt;
          have_prev[c] = 1'b1;
          if (c == realign_chip && relocked) post_checks++;
        end
        if (!locked[c]) have_prev[c] = 1'b0;
        if (lock_watch && c != realign_chip && !locked[c]) begin
          errors++;
          $display("Chip %0d lost lock although its stream never moved.", c);
        end
      end
    end
  end

  task automatic wait_lock_level(input int chip, input bit level, input int limit,
                                 output bit ok);
    ok = 1'b0;
    for (int i = 0; i < limit && !ok; i++) begin
      @(negedge adc_clk);
      ok = (chip < 0) ? (&locked == level) : (locked[chip] == level);
    end
  endtask

  initial begin
    logic [31:0] v;
    bit ok;
    for (int c = 0; c < NC; c++) begin
      for (int w = 0; w < 256; w++) begin
        byte_tab[c][w][0] = 8'h00;
        for (int l = 1; l < NL; l++) begin
          v = take_bits(8);
          byte_tab[c][w][l] = v[7:0];
        end
      end
      v = take_bits(2);
      pair_idx[c] = int'(v[1:0]);  // Starting phase offset in pairs.
      word_cnt[c] = 8'd0;
      insert_req[c] = 1'b0;
      have_prev[c] = 1'b0;
    end
    v = take_bits(3);
    realign_chip = int'(v[2:0]);
    stim_ready = 1'b1;
    repeat (16) @(negedge adc_clk);
    rst_n = 1'b1;
    wait_lock_level(-1, 1'b1, 2000, ok);
    if (!ok) begin
      errors++;
      $display("Timed out waiting for all chips to lock.");
    end else begin
      lock_watch = 1'b1;
      repeat (200) @(negedge adc_clk);
      realigning = 1'b1;  // Words around the extra pair are not judged.
      insert_req[realign_chip] = 1'b1;
      wait_lock_level(realign_chip, 1'b0, 200, ok);
      if (!ok) begin
        errors++;
        $display("Chip %0d kept lock after its stream moved by a pair.", realign_chip);
      end else begin
        wait_lock_level(realign_chip, 1'b1, 2000, ok);
        if (!ok) begin
          errors++;
          $display("Timed out waiting for chip %0d to lock again.", realign_chip);
        end else begin
          realigning = 1'b0;
          relocked = 1'b1;
          repeat (200) @(negedge adc_clk);
          if (post_checks == 0) begin
            errors++;
            $display("No data was checked on chip %0d after it locked again.", realign_chip);
          end
        end
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/adc_link_pkg.sv
design/adc_align_pkg.sv
design/adc_ddr_capture.sv
design/adc_frame_deser.sv
design/adc_frame_aligner.sv
design/adc_capture_top.sv
sim/adc_capture_properties.sv
sim/adc_capture_tb.sv

//--- Makefile
# Verilator build for the ADC capture testbench.

VERILATOR ?= verilator
TOP       ?= adc_capture_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
